/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := histPeakTb
FILELIST := filelist.f
OBJDIR   := obj_dir

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build output"
	@echo "make help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf $(OBJDIR)

/* filelist.f */
src/histPkg.sv
src/binMapper.sv
src/histAccumulator.sv
src/peakFinder.sv
src/windowCalc.sv
src/histPeakTop.sv
tests/histPeak_properties.sv
tests/histPeakTb.sv

/* src/binMapper.sv */
`timescale 1ns/1ps

module binMapper
    import histPkg::*;
(
    input  logic [SAMPLE_W-1:0] sample,
    input  passT                pass,
    input  windowT              window,
    output logic [BIN_W-1:0]    binAddr,
    output logic                inWindow
);

    // distance of the sample from the window start
    logic [SAMPLE_W-1:0] offset;
    logic                aboveLow;
    logic                belowHigh;

    // wraps for samples under the window, masked by inWindow then
    assign offset = sample - window.low;

    // both limits inclusive
    assign aboveLow  = (sample >= window.low);
    assign belowHigh = (sample <= window.high);

    always_comb begin
        if (pass == PASS_COARSE) begin
            // coarse bin is just the top bits of the code
            binAddr  = BIN_W'(sample >> COARSE_SHIFT);
            // every sample lands somewhere in the coarse pass
            inWindow = 1'b1;
        end else begin
            // one code per bin inside the window
            binAddr  = offset[BIN_W-1:0];
            // out-of-window samples still count toward N_SAMPLES upstream
            inWindow = aboveLow && belowHigh;
        end
    end

endmodule

/* src/histAccumulator.sv */
`timescale 1ns/1ps

module histAccumulator
    import histPkg::*;
#(
    parameter int N_SAMPLES = 32,
    parameter int CNT_W     = $clog2(N_SAMPLES + 1)
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             wrEn,
    input  logic [BIN_W-1:0] binAddr,
    input  logic             inWindow,
    output logic             passDone,
    output passT             pass,
    output logic             ready,
    input  logic [BIN_W-1:0] rdAddr,
    output logic [CNT_W-1:0] rdCount,
    input  logic             peakDone
);

    typedef enum logic [1:0] {
        CLEARING = 2'd0,
        COUNTING = 2'd1,
        SCANNING = 2'd2
    } stateT;

    stateT state;

    // bin counters, wiped by the clear sweep instead of reset
    logic [CNT_W-1:0] binCount [NUM_BINS];

    // clear sweep pointer
    logic [BIN_W-1:0] clrAddr;

    // accepted samples in this pass, including out-of-window ones
    logic [CNT_W-1:0] sampleCnt;

    logic accept;
    logic lastSample;
    logic lastClear;

    // samples only taken while counting
    assign ready  = (state == COUNTING);
    assign accept = wrEn && ready;

    assign lastSample = (sampleCnt == CNT_W'(N_SAMPLES - 1));
    assign lastClear  = (clrAddr == BIN_W'(NUM_BINS - 1));

    // scan port, async read of the counter array
    assign rdCount = binCount[rdAddr];

    // control FSM
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= CLEARING;
            clrAddr   <= '0;
            sampleCnt <= '0;
            pass      <= PASS_COARSE;
            passDone  <= 1'b0;
        end else begin
            passDone <= 1'b0;
            case (state)
                CLEARING: begin
                    // one counter per cycle, 16 cycles total
                    clrAddr <= clrAddr + 1'b1;
                    if (lastClear) begin
                        state <= COUNTING;
                    end
                end
                COUNTING: begin
                    if (accept) begin
                        if (lastSample) begin
                            // pass full, hand over to the peak scan
                            sampleCnt <= '0;
                            passDone  <= 1'b1;
                            state     <= SCANNING;
                        end else begin
                            sampleCnt <= sampleCnt + 1'b1;
                        end
                    end
                end
                SCANNING: begin
                    // scan finished, wipe and flip pass
                    if (peakDone) begin
                        state   <= CLEARING;
                        clrAddr <= '0;
                        if (pass == PASS_COARSE) begin
                            pass <= PASS_FINE;
                        end else begin
                            pass <= PASS_COARSE;
                        end
                    end
                end
                default: begin
                    state <= CLEARING;
                end
            endcase
        end
    end

    // counter array update
    always_ff @(posedge clk) begin
        if (state == CLEARING) begin
            binCount[clrAddr] <= '0;
        end else if (accept && inWindow) begin
            // no saturation needed, a bin never exceeds N_SAMPLES
            binCount[binAddr] <= binCount[binAddr] + 1'b1;
        end
    end

endmodule

/* src/histPeakTop.sv */
`timescale 1ns/1ps

module histPeakTop
    import histPkg::*;
#(
    parameter int N_SAMPLES = 32,
    parameter int CNT_W     = $clog2(N_SAMPLES + 1)
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                wrEn,
    input  logic [SAMPLE_W-1:0] sample,
    output logic                ready,
    output logic                coarseDone,
    output peakT                coarsePeak,
    output logic                resultValid,
    output peakT                result,
    output logic [SAMPLE_W-1:0] peakCode
);

    logic [BIN_W-1:0] binAddr;
    logic             inWindow;
    passT             pass;
    windowT           window;
    logic             passDone;
    logic [BIN_W-1:0] rdAddr;
    logic [CNT_W-1:0] rdCount;
    logic             peakDone;
    peakT             peak;
    logic             load;

    // pass still holds the old value during peakDone
    assign load        = peakDone && (pass == PASS_COARSE);
    assign coarseDone  = load;
    assign resultValid = peakDone && (pass == PASS_FINE);

    // same scan result feeds both outputs
    assign coarsePeak = peak;
    assign result     = peak;

    // fine bin back to an absolute code
    assign peakCode = window.low + SAMPLE_W'(peak.bin);

    binMapper u_binMapper (
        .sample   (sample),
        .pass     (pass),
        .window   (window),
        .binAddr  (binAddr),
        .inWindow (inWindow)
    );

    histAccumulator #(
        .N_SAMPLES (N_SAMPLES),
        .CNT_W     (CNT_W)
    ) u_histAccumulator (
        .clk      (clk),
        .rst      (rst),
        .wrEn     (wrEn),
        .binAddr  (binAddr),
        .inWindow (inWindow),
        .passDone (passDone),
        .pass     (pass),
        .ready    (ready),
        .rdAddr   (rdAddr),
        .rdCount  (rdCount),
        .peakDone (peakDone)
    );

    peakFinder #(
        .CNT_W (CNT_W)
    ) u_peakFinder (
        .clk      (clk),
        .rst      (rst),
        .passDone (passDone),
        .rdAddr   (rdAddr),
        .rdCount  (rdCount),
        .peakDone (peakDone),
        .peak     (peak)
    );

    windowCalc u_windowCalc (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .coarseBin (peak.bin),
        .window    (window)
    );

endmodule

/* src/histPkg.sv */
package histPkg;

    // raw sample width from the front end
    parameter int SAMPLE_W = 8;

    // bin address width, same for both passes
    parameter int BIN_W = 4;
    parameter int NUM_BINS = 1 << BIN_W;

    // coarse bin spans 16 codes
    parameter int COARSE_SHIFT = 4;
    parameter int COARSE_SPAN = 1 << COARSE_SHIFT;

    // fine window is one code per bin
    parameter int WIN_SIZE = NUM_BINS;
    parameter int WIN_HALF = WIN_SIZE / 2;

    // highest low limit that keeps the window inside the code range
    parameter int WIN_LOW_MAX = (1 << SAMPLE_W) - WIN_SIZE;

    // count field is sized for the widest supported CNT_W
    parameter int MAX_CNT_W = 8;

    // which histogram is being built
    typedef enum logic {
        PASS_COARSE = 1'b0,
        PASS_FINE   = 1'b1
    } passT;

    // fine window limits, both inclusive
    typedef struct packed {
        logic [SAMPLE_W-1:0] low;
        logic [SAMPLE_W-1:0] high;
    } windowT;

    // peak bin and its count
    // only the low CNT_W bits of count are meaningful
    typedef struct packed {
        logic [BIN_W-1:0]     bin;
        logic [MAX_CNT_W-1:0] count;
    } peakT;

endpackage

/* src/peakFinder.sv */
`timescale 1ns/1ps

module peakFinder
    import histPkg::*;
#(
    parameter int CNT_W = 6
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             passDone,
    output logic [BIN_W-1:0] rdAddr,
    input  logic [CNT_W-1:0] rdCount,
    output logic             peakDone,
    output peakT             peak
);

    logic scanning;
    logic lastRead;
    logic larger;

    // running maximum
    logic [BIN_W-1:0] maxBin;
    logic [CNT_W-1:0] maxCount;

    // final read is bin 15
    assign lastRead = scanning && (rdAddr == BIN_W'(NUM_BINS - 1));

    // strict compare, so ties keep the lower bin
    assign larger = (rdCount > maxCount);

    // scan sequencing
    always_ff @(posedge clk) begin
        if (rst) begin
            scanning <= 1'b0;
            rdAddr   <= '0;
            peakDone <= 1'b0;
        end else begin
            // done one cycle after the last read
            peakDone <= lastRead;
            if (passDone) begin
                scanning <= 1'b1;
                rdAddr   <= '0;
            end else if (scanning) begin
                rdAddr <= rdAddr + 1'b1;
                if (lastRead) begin
                    scanning <= 1'b0;
                end
            end
        end
    end

    // maximum tracking
    always_ff @(posedge clk) begin
        if (passDone) begin
            // empty histogram reports bin 0 with count 0
            maxBin   <= '0;
            maxCount <= '0;
        end else if (scanning && larger) begin
            maxBin   <= rdAddr;
            maxCount <= rdCount;
        end
    end

    // upper count bits stay zero
    assign peak = '{bin: maxBin, count: MAX_CNT_W'(maxCount)};

endmodule

/* src/windowCalc.sv */
`timescale 1ns/1ps

module windowCalc
    import histPkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             load,
    input  logic [BIN_W-1:0] coarseBin,
    output windowT           window
);

    // signed so the bin 0 case goes negative before clamping
    int                  lowRaw;
    logic [SAMPLE_W-1:0] lowClamped;

    always_comb begin
        // first code of the coarse bin, pulled back by half a window
        lowRaw = int'(coarseBin) * COARSE_SPAN - WIN_HALF;
        if (lowRaw < 0) begin
            lowClamped = '0;
        end else if (lowRaw > WIN_LOW_MAX) begin
            lowClamped = SAMPLE_W'(WIN_LOW_MAX);
        end else begin
            lowClamped = SAMPLE_W'(lowRaw);
        end
    end

    // held until the next coarse peak
    always_ff @(posedge clk) begin
        if (rst) begin
            window <= '0;
        end else if (load) begin
            window.low  <= lowClamped;
            // high never wraps since low is at most 240
            window.high <= lowClamped + SAMPLE_W'(WIN_SIZE - 1);
        end
    end

endmodule

/* tests/histPeakTb.sv */
`timescale 1ns/1ps

module histPeakTb
    import histPkg::*;
();

    localparam int N_SAMPLES = 32;
    localparam int CNT_W     = $clog2(N_SAMPLES + 1);
    localparam int N_TABLE   = 8;
    localparam int N_RANDOM  = 6;
    // two passes per run, plus the reset run and the run after it
    localparam int CYCLE_LIMIT = (N_TABLE + N_RANDOM + 2) * 2 * (N_SAMPLES + 40) + 200;

    // nA samples of codeA, nB of codeB, the rest codeC, same set in both passes
    typedef struct packed {
        logic [SAMPLE_W-1:0] codeA;
        logic [7:0]          nA;
        logic [SAMPLE_W-1:0] codeB;
        logic [7:0]          nB;
        logic [SAMPLE_W-1:0] codeC;
        logic [BIN_W-1:0]    coarseBin;
        logic [7:0]          coarseCnt;
        logic [SAMPLE_W-1:0] fineCode;
        logic [7:0]          fineCnt;
    } runT;

    logic                clk;
    logic                rst;
    logic                wrEn;
    logic [SAMPLE_W-1:0] sample;
    logic                ready;
    logic                coarseDone;
    peakT                coarsePeak;
    logic                resultValid;
    peakT                result;
    logic [SAMPLE_W-1:0] peakCode;

    runT                 runTable [N_TABLE];
    logic [SAMPLE_W-1:0] passSamples [N_SAMPLES];
    logic [31:0]         rngState;
    int                  cycles;
    peakT                gotPeak;
    logic [SAMPLE_W-1:0] gotCode;
    int                  expBin;
    int                  expCnt;
    int                  expLow;

    histPeakTop #(.N_SAMPLES(N_SAMPLES), .CNT_W(CNT_W)) u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // run limit from the number of passes
    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > CYCLE_LIMIT) begin
                abortRun($sformatf("timeout: no done pulse within %0d cycles", CYCLE_LIMIT));
            end
        end
    end

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            abortRun($sformatf("FAILED at %0t: %s = %0h, expected %0h",
                               $time, name, actual, expected));
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // coarse peak bin centred in a 16-code window, kept in 0..240
    function automatic int windowLow(input int bin);
        int low;
        low = bin * 16 - 8;
        if (low < 0) begin
            low = 0;
        end else if (low > 240) begin
            low = 240;
        end
        return low;
    endfunction

    // histogram of passSamples and its fullest bin, lowest bin on a tie
    task automatic modelPass(input int low, input bit fine, output int bin, output int cnt);
        int counts [16];
        int code;
        foreach (counts[i]) begin
            counts[i] = 0;
        end
        for (int i = 0; i < N_SAMPLES; i++) begin
            code = int'(passSamples[i]);
            if (!fine) begin
                counts[code / 16]++;
            end else if (code >= low && code <= low + 15) begin
                counts[code - low]++;
            end
        end
        bin = 0;
        cnt = counts[0];
        for (int i = 1; i < 16; i++) begin
            if (counts[i] > cnt) begin
                bin = i;
                cnt = counts[i];
            end
        end
    endtask

    // feeds one pass and waits for its done pulse
    // junk goes out with wrEn high whenever ready is low
    task automatic feedPass(input bit fine);
        int idx;
        bit seen;
        idx = 0;
        seen = 1'b0;
        while (!seen) begin
            @(negedge clk);
            if (fine ? coarseDone : resultValid) begin
                abortRun($sformatf("wrong done pulse at %0t during the %s pass",
                                   $time, fine ? "fine" : "coarse"));
            end
            if (fine ? resultValid : coarseDone) begin
                if (idx != N_SAMPLES) begin
                    abortRun($sformatf("done pulse at %0t after only %0d samples", $time, idx));
                end
                seen = 1'b1;
                gotPeak = fine ? result : coarsePeak;
                gotCode = peakCode;
            end
            wrEn = 1'b1;
            if (ready && idx < N_SAMPLES) begin
                sample = passSamples[idx];
                idx++;
            end else begin
                sample = SAMPLE_W'(cycles * 37);
            end
        end
        wrEn = 1'b0;
    endtask

    task automatic runEntry(input runT run);
        for (int i = 0; i < N_SAMPLES; i++) begin
            if (i < int'(run.nA)) begin
                passSamples[i] = run.codeA;
            end else if (i < int'(run.nA) + int'(run.nB)) begin
                passSamples[i] = run.codeB;
            end else begin
                passSamples[i] = run.codeC;
            end
        end
        feedPass(1'b0);
        checkValue("coarsePeak.bin", 32'(gotPeak.bin), 32'(run.coarseBin));
        checkValue("coarsePeak.count", 32'(gotPeak.count), 32'(run.coarseCnt));
        feedPass(1'b1);
        checkValue("peakCode", 32'(gotCode), 32'(run.fineCode));
        checkValue("result.bin", 32'(gotPeak.bin),
                   int'(run.fineCode) - windowLow(int'(run.coarseBin)));
        checkValue("result.count", 32'(gotPeak.count), 32'(run.fineCnt));
    endtask

    // no done pulse allowed
    task automatic idleCycles(input int n);
        repeat (n) begin
            @(negedge clk);
            checkValue("coarseDone", 32'(coarseDone), 32'd0);
            checkValue("resultValid", 32'(resultValid), 32'd0);
        end
    endtask

    initial begin
        int code;
        rst = 1'b1;
        wrEn = 1'b0;
        sample = '0;
        rngState = 32'h8908_c2a3;
        runTable[0] = '{8'h55, 8'd20, 8'h10, 8'd6,  8'hC3, 4'd5,  8'd20, 8'h55, 8'd20};
        // window clamped to 0
        runTable[1] = '{8'h02, 8'd12, 8'h05, 8'd10, 8'h30, 4'd0,  8'd22, 8'h02, 8'd12};
        // top bin, window 232..247, code FE falls outside
        runTable[2] = '{8'hFE, 8'd9,  8'hF1, 8'd9,  8'hE0, 4'd15, 8'd18, 8'hF1, 8'd9};
        // coarse tie between bins 2 and 4
        runTable[3] = '{8'h23, 8'd12, 8'h47, 8'd12, 8'h90, 4'd2,  8'd12, 8'h23, 8'd12};
        // fine tie between codes 31 and 36
        runTable[4] = '{8'h31, 8'd11, 8'h36, 8'd11, 8'h80, 4'd3,  8'd22, 8'h31, 8'd11};
        runTable[5] = '{8'h80, 8'd32, 8'h00, 8'd0,  8'h00, 4'd8,  8'd32, 8'h80, 8'd32};
        runTable[6] = '{8'h70, 8'd16, 8'h7F, 8'd16, 8'h00, 4'd7,  8'd32, 8'h70, 8'd16};
        // window reaches into the lower coarse bin
        runTable[7] = '{8'h4C, 8'd14, 8'h52, 8'd9,  8'h57, 4'd5,  8'd18, 8'h4C, 8'd14};
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int r = 0; r < N_TABLE; r++) begin
            runEntry(runTable[r]);
        end
        // random coarse set, then fine samples around the model's window
        for (int r = 0; r < N_RANDOM; r++) begin
            for (int i = 0; i < N_SAMPLES; i++) begin
                rngState = xorshift32(rngState);
                passSamples[i] = rngState[SAMPLE_W-1:0];
            end
            modelPass(0, 1'b0, expBin, expCnt);
            feedPass(1'b0);
            checkValue("coarsePeak.bin", 32'(gotPeak.bin), expBin);
            checkValue("coarsePeak.count", 32'(gotPeak.count), expCnt);
            expLow = windowLow(expBin);
            for (int i = 0; i < N_SAMPLES; i++) begin
                rngState = xorshift32(rngState);
                code = expLow - 4 + int'(rngState % 24);
                passSamples[i] = SAMPLE_W'((code < 0) ? 0 : code);
            end
            modelPass(expLow, 1'b1, expBin, expCnt);
            feedPass(1'b1);
            checkValue("peakCode", 32'(gotCode), expLow + expBin);
            checkValue("result.bin", 32'(gotPeak.bin), expBin);
            checkValue("result.count", 32'(gotPeak.count), expCnt);
        end
        // reset while the full fine pass is being scanned
        for (int i = 0; i < N_SAMPLES; i++) begin
            passSamples[i] = 8'h55;
        end
        modelPass(0, 1'b0, expBin, expCnt);
        feedPass(1'b0);
        checkValue("coarsePeak.bin", 32'(gotPeak.bin), expBin);
        checkValue("coarsePeak.count", 32'(gotPeak.count), expCnt);
        while (!ready) begin
            @(negedge clk);
        end
        for (int i = 0; i < N_SAMPLES; i++) begin
            wrEn = 1'b1;
            sample = passSamples[i];
            @(negedge clk);
        end
        rst = 1'b1;
        wrEn = 1'b0;
        idleCycles(5);
        rst = 1'b0;
        idleCycles(40);
        runEntry(runTable[7]);
        $display("Verification passed");
        $finish;
    end

endmodule

/* tests/histPeak_properties.sv */
`timescale 1ns/1ps

module histPeakProperties (
    input logic clk,
    input logic rst,
    input logic ready,
    input logic coarseDone,
    input logic resultValid,
    input logic passDone,
    input logic peakDone
);

    // one kind of done pulse at a time, each a single cycle
    assert property (@(posedge clk) disable iff (rst)
        (coarseDone || resultValid) |=> !(coarseDone || resultValid))
        else $error("done pulse longer than one cycle");

    // no samples taken while a result is out
    assert property (@(posedge clk) disable iff (rst) (coarseDone || resultValid) |-> !ready)
        else $error("ready high during a done pulse");

    // 16 reads plus the compare
    assert property (@(posedge clk) disable iff (rst) peakDone |-> $past(passDone, 17))
        else $error("peakDone not 17 cycles after passDone");

    // ready back after the 16-cycle clear sweep, from a scan or from reset
    assert property (@(posedge clk) disable iff (rst) $rose(ready) |->
        ($past(peakDone, 17) || ($past(rst, 17) && !$past(rst, 16))))
        else $error("ready rose without a full 16-cycle clear sweep");

endmodule

bind histPeakTop histPeakProperties u_props (
    .clk(clk), .rst(rst), .ready(ready), .coarseDone(coarseDone),
    .resultValid(resultValid), .passDone(passDone), .peakDone(peakDone)
);
